//--- verilog/cp0Pkg.sv
/*
 * CP0 shared definitions: register selectors, exception types and codes,
 * field positions, reset values and the constant identity words
 */
package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  cp0Addr_t;     // Register number * 8 + select
    typedef logic [4:0]  excCode_t;

    typedef enum logic [3:0] {
        excIntr,
        excCpU,
        excRi,
        excOv,
        excTrap,
        excSysCall,
        excBp,
        excAdEL,
        excAdES,
        excEret
    } excType_t;

    // Register number in the upper five bits, select in the lower three
    localparam cp0Addr_t addrBadVAddr = {5'd8,  3'd0};
    localparam cp0Addr_t addrCount    = {5'd9,  3'd0};
    localparam cp0Addr_t addrCompare  = {5'd11, 3'd0};
    localparam cp0Addr_t addrStatus   = {5'd12, 3'd0};
    localparam cp0Addr_t addrCause    = {5'd13, 3'd0};
    localparam cp0Addr_t addrEpc      = {5'd14, 3'd0};
    localparam cp0Addr_t addrPrId     = {5'd15, 3'd0};
    localparam cp0Addr_t addrConfig   = {5'd16, 3'd0};
    localparam cp0Addr_t addrConfig1  = {5'd16, 3'd1};

    localparam excCode_t codeIntr    = 5'd0;
    localparam excCode_t codeAdEL    = 5'd4;
    localparam excCode_t codeAdES    = 5'd5;
    localparam excCode_t codeSysCall = 5'd8;
    localparam excCode_t codeBp      = 5'd9;
    localparam excCode_t codeRi      = 5'd10;
    localparam excCode_t codeCpU     = 5'd11;
    localparam excCode_t codeOv      = 5'd12;
    localparam excCode_t codeTrap    = 5'd13;

    localparam int hwIntWidth = 6;

    // Low bit of each field
    localparam int statusCu0   = 28;
    localparam int statusBev   = 22;
    localparam int statusIm    = 8;     // IM is 8 bits wide
    localparam int statusUm    = 4;
    localparam int statusErl   = 2;
    localparam int statusExl   = 1;
    localparam int statusIe    = 0;
    localparam int causeIv     = 23;
    localparam int causeIpSoft = 8;     // IP[1:0]
    localparam int configK0    = 0;

    localparam logic [2:0] k0Reset = 3'd2;  // Uncached

    // Company 0x01, processor 0x80
    localparam word_t prIdValue = {8'h00, 8'h01, 8'h80, 8'h00};

    // Config1 set-count codes, 64 sets shifted by the code
    localparam logic [2:0] iCacheSets = 3'd1;
    localparam logic [2:0] dCacheSets = 3'd1;

    // M set, little endian, MIPS32 R1, MT = no MMU, K0 filled in by the register
    localparam word_t configReadOnly = {
        1'b1, 6'b0, 9'b0, 1'b0, 2'b0, 3'b0, 3'b000, 3'b0, 1'b0, 3'b0
    };

    // No Config2, MMU size 0, 64-byte lines, direct mapped
    localparam word_t config1Value = {
        1'b0,
        6'd0,
        iCacheSets, 3'd5, 3'd0,
        dCacheSets, 3'd5, 3'd0,
        7'b0
    };

endpackage

//--- verilog/cp0AccessDecode.sv
/*
 * CP0 access decoder: turns the software address into write strobes
 * and picks the read word
 */
module cp0AccessDecode (
    input  cp0Pkg::cp0Addr_t addr_i,
    input  logic             wen_i,
    input  logic             excFlag_i,
    input  cp0Pkg::word_t    statusWord_i,
    input  cp0Pkg::word_t    causeWord_i,
    input  cp0Pkg::word_t    configWord_i,
    input  cp0Pkg::word_t    epcWord_i,
    input  cp0Pkg::word_t    badVAddrWord_i,
    input  cp0Pkg::word_t    countWord_i,
    input  cp0Pkg::word_t    compareWord_i,
    output logic             wrBadVAddr_o,
    output logic             wrCount_o,
    output logic             wrCompare_o,
    output logic             wrStatus_o,
    output logic             wrCause_o,
    output logic             wrEpc_o,
    output logic             wrConfig_o,
    output cp0Pkg::word_t    rdata_o
);

    logic wrEn;

    // Exception entry always wins over a software write
    assign wrEn = wen_i & ~excFlag_i;

    always_comb begin
        wrBadVAddr_o = 1'b0;
        wrCount_o    = 1'b0;
        wrCompare_o  = 1'b0;
        wrStatus_o   = 1'b0;
        wrCause_o    = 1'b0;
        wrEpc_o      = 1'b0;
        wrConfig_o   = 1'b0;
        rdata_o      = '0;

        case (addr_i)
            cp0Pkg::addrBadVAddr: begin
                wrBadVAddr_o = wrEn;
                rdata_o      = badVAddrWord_i;
            end
            cp0Pkg::addrCount: begin
                wrCount_o = wrEn;
                rdata_o   = countWord_i;
            end
            cp0Pkg::addrCompare: begin
                wrCompare_o = wrEn;
                rdata_o     = compareWord_i;
            end
            cp0Pkg::addrStatus: begin
                wrStatus_o = wrEn;
                rdata_o    = statusWord_i;
            end
            cp0Pkg::addrCause: begin
                wrCause_o = wrEn;
                rdata_o   = causeWord_i;
            end
            cp0Pkg::addrEpc: begin
                wrEpc_o = wrEn;
                rdata_o = epcWord_i;
            end
            cp0Pkg::addrConfig: begin
                wrConfig_o = wrEn;
                rdata_o    = configWord_i;
            end
            cp0Pkg::addrPrId:    rdata_o = cp0Pkg::prIdValue;     // Read only
            cp0Pkg::addrConfig1: rdata_o = cp0Pkg::config1Value;
            default:             rdata_o = '0;
        endcase
    end

endmodule

//--- verilog/cp0StatusCause.sv
/*
 * Status, Cause and Config K0 registers with exception entry and ERET
 */
module cp0StatusCause (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cp0Pkg::hwIntWidth-1:0] hwInt_i,
    input  cp0Pkg::word_t                 wdata_i,
    input  logic                          wrStatus_i,
    input  logic                          wrCause_i,
    input  logic                          wrConfig_i,
    input  logic                          excFlag_i,
    input  cp0Pkg::excType_t              excType_i,
    input  logic [1:0]                    excCpNum_i,
    input  logic                          inSlot_i,
    output cp0Pkg::word_t                 statusWord_o,
    output cp0Pkg::word_t                 causeWord_o,
    output cp0Pkg::word_t                 configWord_o,
    output logic                          captureEpc_o,
    output logic                          captureBadVAddr_o,
    output logic                          userMode_o
);

    logic       cu0, bev, um, erl, exl, ie;
    logic [7:0] im;

    logic                          bd;
    logic [1:0]                    ce;
    logic                          iv;
    logic [cp0Pkg::hwIntWidth-1:0] ipHw;
    logic [1:0]                    ipSoft;
    cp0Pkg::excCode_t              excCode;
    logic [2:0]                    k0;

    logic             isEntry;
    logic             isEret;
    cp0Pkg::excCode_t entryCode;

    always_comb begin
        isEntry   = 1'b1;
        isEret    = 1'b0;
        entryCode = cp0Pkg::codeIntr;
        case (excType_i)
            cp0Pkg::excIntr:    entryCode = cp0Pkg::codeIntr;
            cp0Pkg::excCpU:     entryCode = cp0Pkg::codeCpU;
            cp0Pkg::excRi:      entryCode = cp0Pkg::codeRi;
            cp0Pkg::excOv:      entryCode = cp0Pkg::codeOv;
            cp0Pkg::excTrap:    entryCode = cp0Pkg::codeTrap;
            cp0Pkg::excSysCall: entryCode = cp0Pkg::codeSysCall;
            cp0Pkg::excBp:      entryCode = cp0Pkg::codeBp;
            cp0Pkg::excAdEL:    entryCode = cp0Pkg::codeAdEL;
            cp0Pkg::excAdES:    entryCode = cp0Pkg::codeAdES;
            cp0Pkg::excEret: begin
                isEntry = 1'b0;
                isEret  = 1'b1;
            end
            default:            isEntry = 1'b0;
        endcase
    end

    // Nested exceptions keep the first EPC
    assign captureEpc_o      = excFlag_i & isEntry & ~exl;
    assign captureBadVAddr_o = excFlag_i & (excType_i == cp0Pkg::excAdEL ||
                                            excType_i == cp0Pkg::excAdES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cu0     <= 1'b0;
            bev     <= 1'b1;
            im      <= '0;
            um      <= 1'b0;
            erl     <= 1'b1;
            exl     <= 1'b0;
            ie      <= 1'b0;
            bd      <= 1'b0;
            ce      <= '0;
            iv      <= 1'b0;
            ipHw    <= '0;
            ipSoft  <= '0;
            excCode <= cp0Pkg::codeIntr;
            k0      <= cp0Pkg::k0Reset;
        end else begin
            ipHw <= hwInt_i;   // One cycle behind the pins

            if (excFlag_i) begin
                if (isEntry) begin
                    exl     <= 1'b1;
                    excCode <= entryCode;
                    if (!exl) begin
                        bd <= inSlot_i;
                    end
                    if (excType_i == cp0Pkg::excCpU) begin
                        ce <= excCpNum_i;
                    end
                end else if (isEret) begin
                    exl <= 1'b0;
                end
            end else begin
                if (wrStatus_i) begin
                    cu0 <= wdata_i[cp0Pkg::statusCu0];
                    bev <= wdata_i[cp0Pkg::statusBev];
                    im  <= wdata_i[cp0Pkg::statusIm +: 8];
                    um  <= wdata_i[cp0Pkg::statusUm];
                    erl <= wdata_i[cp0Pkg::statusErl];
                    exl <= wdata_i[cp0Pkg::statusExl];
                    ie  <= wdata_i[cp0Pkg::statusIe];
                end
                if (wrCause_i) begin
                    iv     <= wdata_i[cp0Pkg::causeIv];
                    ipSoft <= wdata_i[cp0Pkg::causeIpSoft +: 2];
                end
                if (wrConfig_i) begin
                    k0 <= wdata_i[cp0Pkg::configK0 +: 3];
                end
            end
        end
    end

    assign statusWord_o = {
        3'b0, cu0, 5'b0, bev, 6'b0, im, 3'b0, um, 1'b0, erl, exl, ie
    };

    assign causeWord_o = {
        bd, 1'b0, ce, 4'b0, iv, 7'b0, ipHw, ipSoft, 1'b0, excCode, 2'b0
    };

    always_comb begin
        configWord_o = cp0Pkg::configReadOnly;
        configWord_o[cp0Pkg::configK0 +: 3] = k0;
    end

    assign userMode_o = um & ~(erl | exl);

endmodule

//--- verilog/cp0ExcAddr.sv
/*
 * EPC and BadVAddr, loaded on exception entry or by software
 */
module cp0ExcAddr (
    input  logic          clk,
    input  logic          rst,
    input  cp0Pkg::word_t pc_i,
    input  cp0Pkg::word_t excBadAddr_i,
    input  logic          inSlot_i,
    input  logic          captureEpc_i,
    input  logic          captureBadVAddr_i,
    input  cp0Pkg::word_t wdata_i,
    input  logic          wrEpc_i,
    input  logic          wrBadVAddr_i,
    output cp0Pkg::word_t epcWord_o,
    output cp0Pkg::word_t badVAddrWord_o
);

    cp0Pkg::word_t epc;
    cp0Pkg::word_t badVAddr;
    cp0Pkg::word_t excPc;

    // Delay slot faults restart at the branch
    assign excPc = inSlot_i ? pc_i - 32'd4 : pc_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epc <= '0;
        end else if (captureEpc_i) begin
            epc <= excPc;
        end else if (wrEpc_i) begin
            epc <= wdata_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddr <= '0;
        end else if (captureBadVAddr_i) begin
            badVAddr <= excBadAddr_i;
        end else if (wrBadVAddr_i) begin
            badVAddr <= wdata_i;
        end
    end

    assign epcWord_o      = epc;
    assign badVAddrWord_o = badVAddr;

endmodule

//--- verilog/cp0Timer.sv
/*
 * Count and Compare with the sticky timer interrupt
 */
module cp0Timer (
    input  logic          clk,
    input  logic          rst,
    input  cp0Pkg::word_t wdata_i,
    input  logic          wrCount_i,
    input  logic          wrCompare_i,
    output cp0Pkg::word_t countWord_o,
    output cp0Pkg::word_t compareWord_o,
    output logic          timerInt_o
);

    cp0Pkg::word_t count;
    cp0Pkg::word_t compare;
    logic          hit;

    assign hit = (compare != '0) && (count == compare);   // Zero disables

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count      <= '0;
            compare    <= '0;
            timerInt_o <= 1'b0;
        end else begin
            count <= wrCount_i ? wdata_i : count + 32'd1;

            if (wrCompare_i) begin
                compare    <= wdata_i;
                timerInt_o <= 1'b0;   // Acknowledge
            end else if (hit) begin
                timerInt_o <= 1'b1;
            end
        end
    end

    assign countWord_o   = count;
    assign compareWord_o = compare;

endmodule

//--- verilog/cp0Top.sv
/*
 * CP0 top level: address decoder beside the Status/Cause, exception
 * address and timer register blocks
 */
module cp0Top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cp0Pkg::hwIntWidth-1:0] hwInt_i,
    input  cp0Pkg::cp0Addr_t              addr_i,
    input  logic                          wen_i,
    input  cp0Pkg::word_t                 wdata_i,
    input  logic                          excFlag_i,
    input  cp0Pkg::excType_t              excType_i,
    input  logic [1:0]                    excCpNum_i,
    input  cp0Pkg::word_t                 pc_i,
    input  cp0Pkg::word_t                 excBadAddr_i,
    input  logic                          inSlot_i,
    output cp0Pkg::word_t                 rdata_o,
    output cp0Pkg::word_t                 status_o,
    output cp0Pkg::word_t                 cause_o,
    output cp0Pkg::word_t                 epc_o,
    output cp0Pkg::word_t                 config_o,
    output logic                          userMode_o,
    output logic                          timerInt_o
);

    logic wrBadVAddr, wrCount, wrCompare, wrStatus, wrCause, wrEpc, wrConfig;
    logic captureEpc, captureBadVAddr;

    cp0Pkg::word_t statusWord, causeWord, configWord;
    cp0Pkg::word_t epcWord, badVAddrWord;
    cp0Pkg::word_t countWord, compareWord;

    cp0AccessDecode cp0AccessDecode_i (
        .addr_i         (addr_i),
        .wen_i          (wen_i),
        .excFlag_i      (excFlag_i),
        .statusWord_i   (statusWord),
        .causeWord_i    (causeWord),
        .configWord_i   (configWord),
        .epcWord_i      (epcWord),
        .badVAddrWord_i (badVAddrWord),
        .countWord_i    (countWord),
        .compareWord_i  (compareWord),
        .wrBadVAddr_o   (wrBadVAddr),
        .wrCount_o      (wrCount),
        .wrCompare_o    (wrCompare),
        .wrStatus_o     (wrStatus),
        .wrCause_o      (wrCause),
        .wrEpc_o        (wrEpc),
        .wrConfig_o     (wrConfig),
        .rdata_o        (rdata_o)
    );

    cp0StatusCause cp0StatusCause_i (
        .clk               (clk),
        .rst               (rst),
        .hwInt_i           (hwInt_i),
        .wdata_i           (wdata_i),
        .wrStatus_i        (wrStatus),
        .wrCause_i         (wrCause),
        .wrConfig_i        (wrConfig),
        .excFlag_i         (excFlag_i),
        .excType_i         (excType_i),
        .excCpNum_i        (excCpNum_i),
        .inSlot_i          (inSlot_i),
        .statusWord_o      (statusWord),
        .causeWord_o       (causeWord),
        .configWord_o      (configWord),
        .captureEpc_o      (captureEpc),
        .captureBadVAddr_o (captureBadVAddr),
        .userMode_o        (userMode_o)
    );

    cp0ExcAddr cp0ExcAddr_i (
        .clk               (clk),
        .rst               (rst),
        .pc_i              (pc_i),
        .excBadAddr_i      (excBadAddr_i),
        .inSlot_i          (inSlot_i),
        .captureEpc_i      (captureEpc),
        .captureBadVAddr_i (captureBadVAddr),
        .wdata_i           (wdata_i),
        .wrEpc_i           (wrEpc),
        .wrBadVAddr_i      (wrBadVAddr),
        .epcWord_o         (epcWord),
        .badVAddrWord_o    (badVAddrWord)
    );

    cp0Timer cp0Timer_i (
        .clk           (clk),
        .rst           (rst),
        .wdata_i       (wdata_i),
        .wrCount_i     (wrCount),
        .wrCompare_i   (wrCompare),
        .countWord_o   (countWord),
        .compareWord_o (compareWord),
        .timerInt_o    (timerInt_o)
    );

    // Register words for the pipeline
    assign status_o = statusWord;
    assign cause_o  = causeWord;
    assign epc_o    = epcWord;
    assign config_o = configWord;

endmodule

//--- verification/cp0Tb.sv
/*
 * CP0 testbench: random register writes, exceptions, ERET, timer and
 * interrupt pending checked against a cycle model
 */
module cp0Tb;

    logic clk, rst;
    logic [cp0Pkg::hwIntWidth-1:0] hwInt_i;
    cp0Pkg::cp0Addr_t addr_i;
    logic wen_i, excFlag_i, inSlot_i, userMode_o, timerInt_o;
    cp0Pkg::word_t wdata_i, pc_i, excBadAddr_i;
    cp0Pkg::excType_t excType_i;
    logic [1:0] excCpNum_i;
    cp0Pkg::word_t rdata_o, status_o, cause_o, epc_o, config_o;

    // Values for the next drive edge
    logic [cp0Pkg::hwIntWidth-1:0] nHw;
    cp0Pkg::cp0Addr_t nAddr;
    logic nWen, nExc, nSlot;
    cp0Pkg::word_t nWdata, nPc, nBad;
    cp0Pkg::excType_t nType;
    logic [1:0] nCp;

    // Model state
    cp0Pkg::word_t mCount, mCompare, mEpc, mBad;
    logic mTint, mCu0, mBev, mUm, mErl, mExl, mIe, mBd, mIv;
    logic [7:0] mIm;
    logic [1:0] mCe, mIpSoft;
    logic [5:0] mIpHw;
    cp0Pkg::excCode_t mCode;
    logic [2:0] mK0;

    logic [31:0] seed = 32'hb53445e9;
    int passCount = 0;
    int failCount = 0;
    int testFails;
    string testName;

    cp0Pkg::cp0Addr_t keptAddr[9] = '{cp0Pkg::addrBadVAddr, cp0Pkg::addrCount,
        cp0Pkg::addrCompare, cp0Pkg::addrStatus, cp0Pkg::addrCause, cp0Pkg::addrEpc,
        cp0Pkg::addrPrId, cp0Pkg::addrConfig, cp0Pkg::addrConfig1};

    cp0Top cp0Top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function logic [31:0] nextRandom();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic cp0Pkg::excCode_t excCodeOf(input cp0Pkg::excType_t t);
        case (t)
            cp0Pkg::excCpU:     return cp0Pkg::codeCpU;
            cp0Pkg::excRi:      return cp0Pkg::codeRi;
            cp0Pkg::excOv:      return cp0Pkg::codeOv;
            cp0Pkg::excTrap:    return cp0Pkg::codeTrap;
            cp0Pkg::excSysCall: return cp0Pkg::codeSysCall;
            cp0Pkg::excBp:      return cp0Pkg::codeBp;
            cp0Pkg::excAdEL:    return cp0Pkg::codeAdEL;
            cp0Pkg::excAdES:    return cp0Pkg::codeAdES;
            default:            return cp0Pkg::codeIntr;
        endcase
    endfunction

    function automatic cp0Pkg::word_t expRead(input cp0Pkg::cp0Addr_t a);
        cp0Pkg::word_t w;
        w = '0;
        case (a)
            cp0Pkg::addrBadVAddr: w = mBad;
            cp0Pkg::addrCount:    w = mCount;
            cp0Pkg::addrCompare:  w = mCompare;
            cp0Pkg::addrEpc:      w = mEpc;
            cp0Pkg::addrPrId:     w = cp0Pkg::prIdValue;
            cp0Pkg::addrConfig1:  w = cp0Pkg::config1Value;
            cp0Pkg::addrStatus: begin
                w[cp0Pkg::statusCu0] = mCu0;
                w[cp0Pkg::statusBev] = mBev;
                w[cp0Pkg::statusIm +: 8] = mIm;
                w[cp0Pkg::statusUm] = mUm;
                w[cp0Pkg::statusErl] = mErl;
                w[cp0Pkg::statusExl] = mExl;
                w[cp0Pkg::statusIe] = mIe;
            end
            cp0Pkg::addrCause: begin
                w[31] = mBd;
                w[29:28] = mCe;
                w[cp0Pkg::causeIv] = mIv;
                w[15:10] = mIpHw;
                w[cp0Pkg::causeIpSoft +: 2] = mIpSoft;
                w[6:2] = mCode;
            end
            cp0Pkg::addrConfig: begin
                w = cp0Pkg::configReadOnly;
                w[cp0Pkg::configK0 +: 3] = mK0;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    task modelReset();
        {mCount, mCompare, mEpc, mBad, mTint} = '0;
        {mCu0, mUm, mExl, mIe, mBd, mIv, mIm, mCe, mIpSoft, mIpHw, mCode} = '0;
        mBev = 1'b1;
        mErl = 1'b1;
        mK0 = 3'd2;
    endtask

    // Applies the inputs held during the cycle that ends at this edge
    task modelStep();
        logic wrEn, hit;
        wrEn = wen_i & ~excFlag_i;
        hit = (mCompare != 0) && (mCount == mCompare);
        mIpHw = hwInt_i;
        mCount = (wrEn && addr_i == cp0Pkg::addrCount) ? wdata_i : mCount + 1;
        if (wrEn && addr_i == cp0Pkg::addrCompare) begin
            mCompare = wdata_i;
            mTint = 1'b0;
        end else if (hit) begin
            mTint = 1'b1;
        end
        if (excFlag_i && excType_i == cp0Pkg::excEret) begin
            mExl = 1'b0;
        end else if (excFlag_i) begin
            if (!mExl) begin
                mEpc = inSlot_i ? pc_i - 4 : pc_i;
                mBd = inSlot_i;
            end
            mExl = 1'b1;
            mCode = excCodeOf(excType_i);
            if (excType_i == cp0Pkg::excCpU) mCe = excCpNum_i;
            if (excType_i == cp0Pkg::excAdEL || excType_i == cp0Pkg::excAdES) begin
                mBad = excBadAddr_i;
            end
        end else if (wrEn) begin
            case (addr_i)
                cp0Pkg::addrBadVAddr: mBad = wdata_i;
                cp0Pkg::addrEpc:      mEpc = wdata_i;
                cp0Pkg::addrConfig:   mK0 = wdata_i[cp0Pkg::configK0 +: 3];
                cp0Pkg::addrCause: begin
                    mIv = wdata_i[cp0Pkg::causeIv];
                    mIpSoft = wdata_i[cp0Pkg::causeIpSoft +: 2];
                end
                cp0Pkg::addrStatus: begin
                    mCu0 = wdata_i[cp0Pkg::statusCu0];
                    mBev = wdata_i[cp0Pkg::statusBev];
                    mIm = wdata_i[cp0Pkg::statusIm +: 8];
                    mUm = wdata_i[cp0Pkg::statusUm];
                    mErl = wdata_i[cp0Pkg::statusErl];
                    mExl = wdata_i[cp0Pkg::statusExl];
                    mIe = wdata_i[cp0Pkg::statusIe];
                end
                default: ;
            endcase
        end
    endtask

    task tick();
        @(posedge clk);
        modelStep();
        hwInt_i <= nHw;
        addr_i <= nAddr;
        wen_i <= nWen;
        wdata_i <= nWdata;
        excFlag_i <= nExc;
        excType_i <= nType;
        excCpNum_i <= nCp;
        pc_i <= nPc;
        excBadAddr_i <= nBad;
        inSlot_i <= nSlot;
    endtask

    task compareWord(input string name, input cp0Pkg::word_t exp, input cp0Pkg::word_t act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected %h actual %h", testName, name, exp, act);
            failCount++;
            testFails++;
        end else begin
            passCount++;
        end
    endtask

    task compareBit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s: %s expected %b actual %b", testName, name, exp, act);
            failCount++;
            testFails++;
        end else begin
            passCount++;
        end
    endtask

    // Flags and the register words brought out for the pipeline
    task checkOutputs();
        compareBit("userMode_o", mUm & ~(mErl | mExl), userMode_o);
        compareBit("timerInt_o", mTint, timerInt_o);
        compareWord("status_o", expRead(cp0Pkg::addrStatus), status_o);
        compareWord("cause_o", expRead(cp0Pkg::addrCause), cause_o);
        compareWord("epc_o", expRead(cp0Pkg::addrEpc), epc_o);
        compareWord("config_o", expRead(cp0Pkg::addrConfig), config_o);
    endtask

    task readCheck(input string name, input cp0Pkg::cp0Addr_t a);
        nAddr = a;
        nWen = 1'b0;
        nExc = 1'b0;
        tick();
        @(negedge clk);
        compareWord(name, expRead(a), rdata_o);
        checkOutputs();
    endtask

    task writeReg(input cp0Pkg::cp0Addr_t a, input cp0Pkg::word_t d);
        nAddr = a;
        nWen = 1'b1;
        nWdata = d;
        nExc = 1'b0;
        tick();
        nWen = 1'b0;
    endtask

    task readAll();
        foreach (keptAddr[k]) readCheck($sformatf("read %h", keptAddr[k]), keptAddr[k]);
    endtask

    task endTest();
        $display("test %s done, %0d errors", testName, testFails);
        testFails = 0;
    endtask

    initial begin
        int i, j;
        logic [31:0] r;
        rst = 1'b1;
        {nHw, nAddr, nWen, nExc, nSlot, nWdata, nPc, nBad, nCp} = '0;
        nType = cp0Pkg::excIntr;
        {hwInt_i, addr_i, wen_i, excFlag_i, inSlot_i, wdata_i, pc_i, excBadAddr_i} = '0;
        excCpNum_i = '0;
        excType_i = cp0Pkg::excIntr;
        testFails = 0;
        modelReset();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        testName = "reset";
        readAll();
        readCheck("unknown selector", 8'hff);
        endTest();

        testName = "software writes";
        for (i = 0; i < 40; i++) begin
            r = nextRandom();
            writeReg(keptAddr[r % 9], nextRandom());
            readCheck("readback", keptAddr[r % 9]);
        end
        readAll();
        endTest();

        testName = "exception entry";
        for (i = 0; i < 30; i++) begin
            r = nextRandom();
            nExc = 1'b1;
            nType = cp0Pkg::excType_t'(r % 10);
            nSlot = r[4];
            nCp = r[6:5];
            nPc = nextRandom();
            nBad = nextRandom();
            tick();
            nExc = 1'b0;
            readCheck("epc", cp0Pkg::addrEpc);
            readCheck("cause", cp0Pkg::addrCause);
            readCheck("badvaddr", cp0Pkg::addrBadVAddr);
            readCheck("status", cp0Pkg::addrStatus);
            if (r[8]) begin
                nExc = 1'b1;
                nType = cp0Pkg::excEret;
                tick();
                nExc = 1'b0;
            end
        end
        endTest();

        testName = "eret and user mode";
        writeReg(cp0Pkg::addrStatus, 32'h1 << cp0Pkg::statusUm);
        readCheck("status um", cp0Pkg::addrStatus);
        nAddr = cp0Pkg::addrStatus;
        nWen = 1'b1;
        nWdata = 32'hffff_ffff;   // Must lose to the exception
        nExc = 1'b1;
        nType = cp0Pkg::excSysCall;
        nPc = nextRandom();
        tick();
        readCheck("status after exception", cp0Pkg::addrStatus);
        nExc = 1'b1;
        nType = cp0Pkg::excEret;
        tick();
        readCheck("status after eret", cp0Pkg::addrStatus);
        endTest();

        testName = "timer";
        r = nextRandom();
        writeReg(cp0Pkg::addrCompare, mCount + 4 + r[2:0]);
        for (j = 0; j < 40 && timerInt_o !== 1'b1; j++) begin
            readCheck("count", cp0Pkg::addrCount);
        end
        if (timerInt_o !== 1'b1) begin
            $display("%s: timer interrupt did not rise within 40 cycles", testName);
            failCount++;
            testFails++;
        end
        repeat (5) readCheck("compare", cp0Pkg::addrCompare);
        writeReg(cp0Pkg::addrCompare, 32'h0);
        writeReg(cp0Pkg::addrCount, 32'hffff_fff0);   // Wraps through zero
        repeat (30) readCheck("count", cp0Pkg::addrCount);
        endTest();

        testName = "interrupt pending";
        writeReg(cp0Pkg::addrCause, nextRandom());
        for (i = 0; i < 20; i++) begin
            r = nextRandom();
            nHw = r[5:0];
            readCheck("cause ip", cp0Pkg::addrCause);
        end
        nHw = '0;
        readCheck("cause ip", cp0Pkg::addrCause);
        endTest();

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/cp0Pkg.sv
verilog/cp0AccessDecode.sv
verilog/cp0StatusCause.sv
verilog/cp0ExcAddr.sv
verilog/cp0Timer.sv
verilog/cp0Top.sv
verification/cp0Tb.sv

//--- Bender.yml
package:
  name: cp0

sources:
  - verilog/cp0Pkg.sv
  - verilog/cp0AccessDecode.sv
  - verilog/cp0StatusCause.sv
  - verilog/cp0ExcAddr.sv
  - verilog/cp0Timer.sv
  - verilog/cp0Top.sv
  - target: test
    files:
      - verification/cp0Tb.sv
